//--- logic/roomPkg.sv
package roomPkg;

	// screen geometry
	localparam int screenWidth = 160; // pixel columns
	localparam int screenHeight = 120; // pixel rows

	localparam int roomCount = 5; // one switch per room
	localparam int blockSide = 4; // status block edge in pixels

	typedef logic [7:0] xCoordT; // column, 0..159
	typedef logic [6:0] yCoordT; // row, 0..119
	typedef logic [2:0] colourT; // {r, g, b}

	// block origins, entry 0 is room 0
	localparam xCoordT [roomCount-1:0] roomOriginX = {
		8'd144, // room 4
		8'd112, // room 3
		8'd80, // room 2
		8'd48, // room 1
		8'd16 // room 0
	};
	localparam yCoordT lightOriginY = 7'd24; // light row
	localparam yCoordT doorOriginY = 7'd80; // door row

	localparam colourT colourOn = 3'b110; // yellow
	localparam colourT colourOff = 3'b111; // white
	localparam colourT colourClear = 3'b000; // black

	// one pixel write, 18 bits
	typedef struct packed {
		xCoordT x;
		yCoordT y;
		colourT colour;
	} pixelT;

	// block latched at load release
	typedef struct packed {
		xCoordT originX; // top-left column
		yCoordT originY; // top-left row
		colourT colour; // on or off colour
	} blockCmdT;

endpackage

//--- logic/blockPlotter.sv
`timescale 1ns/10ps

module blockPlotter (
	input logic clock,
	input logic reset,
	input logic loadButton, // load pushbutton level
	input logic [roomPkg::roomCount-1:0] roomSwitches, // one-hot room select
	input logic lightSelect, // 1 light, 0 door
	input logic stateOn, // 1 on, 0 off
	output roomPkg::pixelT plotPixel,
	output logic plotValid,
	input logic plotReady,
	output logic drawBusy
);

	logic loadPrev; // button level last cycle
	logic loadRelease; // high then low
	logic anySwitch; // some room picked
	logic startBlock;
	logic [2:0] roomIndex; // lowest set switch
	logic [3:0] offset; // {row, col} within block
	logic lastPixel;
	logic plotFire; // transfer on the plot link
	roomPkg::blockCmdT nextCmd; // block decoded from the inputs
	roomPkg::blockCmdT blockCmd; // block being drawn

	assign loadRelease = loadPrev & ~loadButton;
	assign anySwitch = |roomSwitches;
	assign startBlock = loadRelease & anySwitch & ~drawBusy; // busy releases dropped
	assign plotFire = plotValid & plotReady;
	assign lastPixel = (offset == 4'(roomPkg::blockSide * roomPkg::blockSide - 1));

	// priority encoder, lowest index wins
	always_comb begin
		roomIndex = '0;
		for (int i = roomPkg::roomCount - 1; i >= 0; i--) begin
			if (roomSwitches[i]) begin
				roomIndex = 3'(i); // later (lower) hits override
			end
		end
	end

	// origin and colour lookup from the package tables
	always_comb begin
		nextCmd.originX = roomPkg::roomOriginX[roomIndex];
		nextCmd.originY = lightSelect ? roomPkg::lightOriginY : roomPkg::doorOriginY;
		nextCmd.colour = stateOn ? roomPkg::colourOn : roomPkg::colourOff;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			loadPrev <= 1'b0;
			drawBusy <= 1'b0;
			offset <= '0;
		end else begin
			loadPrev <= loadButton;
			if (startBlock) begin
				drawBusy <= 1'b1; // first pixel valid next cycle
				offset <= '0;
			end else if (plotFire) begin
				offset <= offset + 4'd1; // wraps to 0 after pixel 15
				if (lastPixel) begin
					drawBusy <= 1'b0; // falls the cycle after the last transfer
				end
			end
		end
	end

	// block payload, captured at the release
	always_ff @(posedge clock) begin
		if (startBlock) begin
			blockCmd <= nextCmd;
		end
	end

	// x moves fastest, then y
	assign plotPixel = '{
		x: blockCmd.originX + {6'd0, offset[1:0]},
		y: blockCmd.originY + {5'd0, offset[3:2]},
		colour: blockCmd.colour
	};
	assign plotValid = drawBusy; // held until the block is done

endmodule

//--- logic/screenClearer.sv
`timescale 1ns/10ps

module screenClearer (
	input logic clock,
	input logic reset,
	input logic clearButton, // clear pushbutton level
	output roomPkg::pixelT clearPixel,
	output logic clearValid,
	input logic clearReady,
	output logic clearBusy
);

	logic buttonPrev; // button level last cycle
	logic clearStart; // rising edge while idle
	logic clearFire; // transfer on the clear link
	logic rowEnd; // last column of a row
	logic lastRow; // bottom row of the screen
	roomPkg::xCoordT clearX;
	roomPkg::yCoordT clearY;

	assign clearStart = clearButton & ~buttonPrev & ~clearBusy;
	assign clearFire = clearValid & clearReady;
	assign rowEnd = (clearX == roomPkg::xCoordT'(roomPkg::screenWidth - 1));
	assign lastRow = (clearY == roomPkg::yCoordT'(roomPkg::screenHeight - 1));

	always_ff @(posedge clock) begin
		if (reset) begin
			buttonPrev <= 1'b0;
			clearBusy <= 1'b0;
			clearX <= '0;
			clearY <= '0;
		end else begin
			buttonPrev <= clearButton;
			if (clearStart) begin
				clearBusy <= 1'b1; // raster starts at (0,0)
				clearX <= '0;
				clearY <= '0;
			end else if (clearFire) begin
				if (rowEnd) begin
					clearX <= '0; // wrap column
					if (lastRow) begin
						clearBusy <= 1'b0; // whole screen written
					end else begin
						clearY <= clearY + 7'd1;
					end
				end else begin
					clearX <= clearX + 8'd1;
				end
			end
		end
	end

	assign clearPixel = '{x: clearX, y: clearY, colour: roomPkg::colourClear};
	assign clearValid = clearBusy;

endmodule

//--- logic/pixelArbiter.sv
`timescale 1ns/10ps

module pixelArbiter (
	input logic clock,
	input logic reset,
	input roomPkg::pixelT clearPixel,
	input logic clearValid,
	output logic clearReady,
	input roomPkg::pixelT plotPixel,
	input logic plotValid,
	output logic plotReady,
	output roomPkg::pixelT pixel,
	output logic pixelValid,
	input logic pixelReady
);

	logic lockValid; // a stalled pixel holds the grant
	logic lockClear; // locked owner, 1 clearer 0 plotter
	logic useClear; // current grant

	// fresh decision only when unlocked, clearer first
	assign useClear = lockValid ? lockClear : clearValid;

	// same-cycle steering, no added latency
	assign pixel = useClear ? clearPixel : plotPixel;
	assign pixelValid = useClear ? clearValid : plotValid;
	assign clearReady = useClear & pixelReady;
	assign plotReady = ~useClear & pixelReady; // loser sees no ready

	always_ff @(posedge clock) begin
		if (reset) begin
			lockValid <= 1'b0;
			lockClear <= 1'b0;
		end else if (pixelValid && !pixelReady) begin
			lockValid <= 1'b1; // stall, keep this source
			lockClear <= useClear;
		end else begin
			lockValid <= 1'b0; // transferred or idle
		end
	end

endmodule

//--- logic/roomDisplay.sv
`timescale 1ns/10ps

module roomDisplay (
	input logic clock,
	input logic reset,
	input logic loadButton,
	input logic clearButton,
	input logic [roomPkg::roomCount-1:0] roomSwitches,
	input logic lightSelect,
	input logic stateOn,
	output roomPkg::pixelT pixel, // to frame buffer
	output logic pixelValid,
	input logic pixelReady,
	output logic drawBusy,
	output logic clearBusy
);

	roomPkg::pixelT plotPixel; // block source
	logic plotValid;
	logic plotReady;
	roomPkg::pixelT clearPixel; // clear source
	logic clearValid;
	logic clearReady;

	blockPlotter plotter0 (
		.clock(clock),
		.reset(reset),
		.loadButton(loadButton),
		.roomSwitches(roomSwitches),
		.lightSelect(lightSelect),
		.stateOn(stateOn),
		.plotPixel(plotPixel),
		.plotValid(plotValid),
		.plotReady(plotReady),
		.drawBusy(drawBusy)
	);

	screenClearer clearer0 (
		.clock(clock),
		.reset(reset),
		.clearButton(clearButton),
		.clearPixel(clearPixel),
		.clearValid(clearValid),
		.clearReady(clearReady),
		.clearBusy(clearBusy)
	);

	pixelArbiter arbiter0 (
		.clock(clock),
		.reset(reset),
		.clearPixel(clearPixel),
		.clearValid(clearValid),
		.clearReady(clearReady),
		.plotPixel(plotPixel),
		.plotValid(plotValid),
		.plotReady(plotReady),
		.pixel(pixel),
		.pixelValid(pixelValid),
		.pixelReady(pixelReady)
	);

endmodule

//--- dv/roomDisplay_assertions.sv
`timescale 1ns/10ps

module roomDisplayAssertions (
	input logic clock,
	input logic reset,
	input roomPkg::pixelT pixel,
	input logic pixelValid,
	input logic pixelReady,
	input logic drawBusy,
	input logic clearBusy
);

	int failCount = 0; // assertion failures so far

	// a stalled pixel keeps its source and value
	stallHold: assert property (@(posedge clock) disable iff (reset)
		pixelValid && !pixelReady |=> pixelValid && $stable(pixel))
		else begin
			failCount++;
			$error("pixel or pixelValid changed during a stall");
		end

	// outputs quiet once reset has been applied
	resetQuiet: assert property (@(posedge clock)
		reset |=> !pixelValid && !drawBusy && !clearBusy)
		else begin
			failCount++;
			$error("pixelValid or a busy flag high during reset");
		end

endmodule

bind roomDisplay roomDisplayAssertions checks0 (
	.clock(clock),
	.reset(reset),
	.pixel(pixel),
	.pixelValid(pixelValid),
	.pixelReady(pixelReady),
	.drawBusy(drawBusy),
	.clearBusy(clearBusy)
);

//--- dv/roomDisplayTb.sv
`timescale 1ns/10ps

module roomDisplayTb;

	localparam logic [31:0] seed = 32'h6e0bcff0;
	localparam int clearPixels = roomPkg::screenWidth * roomPkg::screenHeight; // 19200

	logic clock = 1'b0;
	logic reset;
	logic loadButton;
	logic clearButton;
	logic [roomPkg::roomCount-1:0] roomSwitches;
	logic lightSelect;
	logic stateOn;
	roomPkg::pixelT pixel;
	logic pixelValid;
	logic pixelReady = 1'b0;
	logic drawBusy;
	logic clearBusy;

	logic [31:0] stimState; // switches and selectors
	logic [31:0] readyState = ~seed; // separate stream for back-pressure
	roomPkg::pixelT expectedBlock[$]; // block pixels still to arrive
	int clearIndex; // raster position of the next clear pixel
	bit clearArmed;
	int mismatchCount = 0;
	int timeoutCount = 0;

	roomDisplay dut0 (
		.clock(clock),
		.reset(reset),
		.loadButton(loadButton),
		.clearButton(clearButton),
		.roomSwitches(roomSwitches),
		.lightSelect(lightSelect),
		.stateOn(stateOn),
		.pixel(pixel),
		.pixelValid(pixelValid),
		.pixelReady(pixelReady),
		.drawBusy(drawBusy),
		.clearBusy(clearBusy)
	);

	always #10 clock = ~clock; // 20 ns period

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] v;
		v = s;
		v = v ^ (v << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	// ready high about three cycles in four
	always @(posedge clock) begin
		#2;
		readyState = xorshift32(readyState);
		pixelReady = (readyState[1:0] != 2'b00);
	end

	task automatic comparePixel(input roomPkg::pixelT got, input roomPkg::pixelT want,
		input string what);
		if (got !== want) begin
			mismatchCount++;
			$display("mismatch at %0t: %s got (%0d,%0d) colour %b, expected (%0d,%0d) colour %b",
				$time, what, got.x, got.y, got.colour, want.x, want.y, want.colour);
		end
	endtask

	task automatic compareBusy(input logic got, input logic want, input string what);
		if (got !== want) begin
			mismatchCount++;
			$display("mismatch at %0t: %s is %b, expected %b", $time, what, got, want);
		end
	endtask

	// expected raster of one block, lowest set switch wins
	task automatic queueBlock(input logic [4:0] sw, input logic light, input logic on);
		int room;
		roomPkg::pixelT p;
		room = -1;
		for (int i = 0; i < roomPkg::roomCount; i++) begin
			if (sw[i] && room < 0) begin
				room = i;
			end
		end
		for (int row = 0; row < 4; row++) begin
			for (int col = 0; col < 4; col++) begin
				p.x = roomPkg::xCoordT'(16 + 32 * room + col); // origins 16, 48 .. 144
				p.y = roomPkg::yCoordT'((light ? 24 : 80) + row);
				p.colour = on ? 3'b110 : 3'b111; // yellow on, white off
				expectedBlock.push_back(p);
			end
		end
	endtask

	task automatic checkClearPixel(input roomPkg::pixelT got);
		roomPkg::pixelT want;
		if (!clearArmed || clearIndex >= clearPixels) begin
			mismatchCount++;
			$display("mismatch at %0t: black pixel (%0d,%0d) with no clear running",
				$time, got.x, got.y);
		end else begin
			want.x = roomPkg::xCoordT'(clearIndex % roomPkg::screenWidth);
			want.y = roomPkg::yCoordT'(clearIndex / roomPkg::screenWidth);
			want.colour = 3'b000;
			comparePixel(got, want, "clear pixel");
			clearIndex++;
		end
	endtask

	task automatic checkBlockPixel(input roomPkg::pixelT got);
		if (expectedBlock.size() == 0) begin
			mismatchCount++;
			$display("mismatch at %0t: block pixel (%0d,%0d) with no block running",
				$time, got.x, got.y);
		end else begin
			comparePixel(got, expectedBlock.pop_front(), "block pixel");
		end
	endtask

	// outputs settled at the falling edge, transfer happens at the next rise
	always @(negedge clock) begin
		if (!reset && pixelValid === 1'b1 && pixelReady === 1'b1) begin
			if (pixel.colour == 3'b000) begin
				checkClearPixel(pixel); // black belongs to the clearer
			end else begin
				checkBlockPixel(pixel);
			end
		end
	end

	task automatic releaseLoad(input logic [4:0] sw, input logic light, input logic on,
		input bit accept, input logic busyAfter);
		@(posedge clock);
		#2;
		roomSwitches = sw;
		lightSelect = light;
		stateOn = on;
		loadButton = 1'b1;
		@(posedge clock);
		#2;
		loadButton = 1'b0; // release sampled at the next edge
		if (accept) begin
			queueBlock(sw, light, on);
		end
		@(posedge clock);
		#2;
		compareBusy(drawBusy, busyAfter, "drawBusy after release");
	endtask

	task automatic pressClear();
		@(posedge clock);
		#2;
		clearButton = 1'b1;
		clearIndex = 0;
		clearArmed = 1'b1;
		@(posedge clock);
		#2;
		clearButton = 1'b0;
		compareBusy(clearBusy, 1'b1, "clearBusy after press");
	endtask

	task automatic waitIdle(input bit clearSide, input int limit, input string name);
		int cycles;
		cycles = 0;
		while ((clearSide ? clearBusy : drawBusy) !== 1'b0 && cycles < limit) begin
			@(posedge clock);
			#2;
			cycles++;
		end
		if ((clearSide ? clearBusy : drawBusy) !== 1'b0) begin
			timeoutCount++;
			$display("timeout: %s still high after %0d cycles", name, limit);
		end
	endtask

	task automatic checkBlockDone();
		if (expectedBlock.size() != 0) begin
			mismatchCount++;
			$display("mismatch at %0t: %0d block pixels never arrived", $time,
				expectedBlock.size());
			expectedBlock.delete();
		end
	endtask

	task automatic checkClearDone();
		if (clearIndex != clearPixels) begin
			mismatchCount++;
			$display("mismatch at %0t: clear wrote %0d pixels, expected %0d", $time,
				clearIndex, clearPixels);
		end
		clearArmed = 1'b0;
	endtask

	initial begin
		logic [4:0] sw;
		int errorTotal;
		stimState = seed;
		reset = 1'b1;
		loadButton = 1'b0;
		clearButton = 1'b0;
		roomSwitches = '0;
		lightSelect = 1'b0;
		stateOn = 1'b0;
		clearIndex = 0;
		clearArmed = 1'b0;
		repeat (8) @(posedge clock);
		#2;
		reset = 1'b0;
		compareBusy(pixelValid, 1'b0, "pixelValid after reset");
		compareBusy(drawBusy, 1'b0, "drawBusy after reset");
		compareBusy(clearBusy, 1'b0, "clearBusy after reset");
		repeat (10) @(posedge clock); // idle, monitor flags any transfer

		for (int n = 0; n < 12; n++) begin
			stimState = xorshift32(stimState);
			sw = stimState[4:0]; // zero means an ignored release
			releaseLoad(sw, stimState[8], stimState[12], sw != 0, sw != 0);
			waitIdle(1'b0, 200, "drawBusy");
			checkBlockDone();
		end

		releaseLoad(5'b00000, 1'b1, 1'b1, 1'b0, 1'b0); // no room picked
		repeat (20) @(posedge clock);
		releaseLoad(5'b00100, 1'b0, 1'b1, 1'b1, 1'b1);
		releaseLoad(5'b00001, 1'b1, 1'b0, 1'b0, 1'b1); // dropped while drawing
		waitIdle(1'b0, 200, "drawBusy");
		checkBlockDone();

		pressClear();
		waitIdle(1'b1, 60000, "clearBusy");
		checkClearDone();

		// clear lands in the middle of a block
		stimState = xorshift32(stimState);
		sw = stimState[4:0] | 5'b10000;
		releaseLoad(sw, stimState[8], stimState[12], 1'b1, 1'b1);
		repeat (5) @(posedge clock);
		pressClear();
		waitIdle(1'b1, 60000, "clearBusy");
		checkClearDone();
		waitIdle(1'b0, 200, "drawBusy");
		checkBlockDone();
		repeat (10) @(posedge clock);

		errorTotal = mismatchCount + timeoutCount + dut0.checks0.failCount;
		$display("mismatches %0d, timeouts %0d, assertion failures %0d", mismatchCount,
			timeoutCount, dut0.checks0.failCount);
		if (errorTotal == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

//--- vlog.f
logic/roomPkg.sv
logic/blockPlotter.sv
logic/screenClearer.sv
logic/pixelArbiter.sv
logic/roomDisplay.sv
dv/roomDisplay_assertions.sv
dv/roomDisplayTb.sv

//--- run.sh
#!/bin/sh
# build and run the room display testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
	--top-module roomDisplayTb -Mdir obj_dir -o roomDisplaySim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/roomDisplaySim +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "TESTBENCH PASSED"; then
	exit 0
fi
exit 1
